// ==== sources.f ====
+incdir+hw
hw/bitmanip_pkg.sv
hw/pipe_stage.sv
hw/bit_decoder.sv
hw/bit_alu.sv
hw/bit_exec_unit.sv
tb/bit_exec_asserts.sv
tb/bit_exec_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= bit_exec_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@! grep -q "TEST RESULT: FAIL" $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb/bit_exec_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module bit_exec_tb;
  import bitmanip_pkg::*;

  localparam int clk_period   = 8;
  localparam int sample_delay = 3;
  localparam int num_random   = 1500;
  localparam int num_burst    = 64;
  localparam int num_txn      = num_random + num_burst;
  localparam int watchdog_ns  = num_txn * 20 * clk_period + 1000;
  localparam int num_legal    = 29;
  localparam int drain_cycles = 20;

  typedef struct packed {
    exec_rsp_type rsp;
    logic         timed;
    logic [31:0]  cycle;
  } sb_entry_type;

  logic         clk;
  logic         rst_n;
  exec_req_type req;
  logic         req_valid;
  logic         req_ready;
  exec_rsp_type rsp;
  logic         rsp_valid;
  logic         rsp_ready = 1'b0;

  sb_entry_type sb_q[$];
  int           sent;
  int           issued;
  int           received;
  int           res_errors;
  int           illegal_errors;
  int           flow_errors;
  int           stall_left;
  logic         full_rate;
  logic         burst_mode;
  logic [31:0]  cycle_cnt;
  logic [31:0]  last_rsp_cycle;
  logic         last_timed;

  bit_exec_unit uut (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req),
    .req_valid(req_valid),
    .req_ready(req_ready),
    .rsp      (rsp),
    .rsp_valid(rsp_valid),
    .rsp_ready(rsp_ready)
  );

  initial begin
    clk = 1'b0;
  end

  always #(clk_period / 2) clk = ~clk;

  // Expected response from the RISC-V field definitions.
  function automatic exec_rsp_type ref_exec(input exec_req_type r);
    logic [6:0]   opc;
    logic [2:0]   f3;
    logic [6:0]   f7;
    logic [4:0]   f5;
    logic [31:0]  a;
    logic [31:0]  b;
    logic [31:0]  res;
    logic [4:0]   sh;
    logic         ok;
    int           cnt;
    exec_rsp_type out;
    opc = r.instr[6:0];
    f3 = r.instr[14:12];
    f7 = r.instr[31:25];
    f5 = r.instr[24:20];
    a = r.rs1;
    b = (opc == opcode_op_imm) ? {27'd0, f5} : r.rs2;
    sh = b[4:0];
    res = '0;
    cnt = 0;
    ok = 1'b1;
    case ({opc, f7, f3})
      {opcode_op, 7'h10, 3'd2}: res = (a << 1) + b;
      {opcode_op, 7'h10, 3'd4}: res = (a << 2) + b;
      {opcode_op, 7'h10, 3'd6}: res = (a << 3) + b;
      {opcode_op, 7'h20, 3'd7}: res = a & ~b;
      {opcode_op, 7'h20, 3'd6}: res = a | ~b;
      {opcode_op, 7'h20, 3'd4}: res = ~(a ^ b);
      {opcode_op, 7'h05, 3'd4}: res = ($signed(a) < $signed(b)) ? a : b;
      {opcode_op, 7'h05, 3'd5}: res = (a < b) ? a : b;
      {opcode_op, 7'h05, 3'd6}: res = ($signed(a) > $signed(b)) ? a : b;
      {opcode_op, 7'h05, 3'd7}: res = (a > b) ? a : b;
      {opcode_op, 7'h30, 3'd1}: res = (a << sh) | (a >> (6'd32 - sh));
      {opcode_op, 7'h30, 3'd5},
      {opcode_op_imm, 7'h30, 3'd5}: res = (a >> sh) | (a << (6'd32 - sh));
      {opcode_op, 7'h04, 3'd4}: begin
        ok = (f5 == 5'd0);
        res = {16'd0, a[15:0]};
      end
      {opcode_op, 7'h24, 3'd1},
      {opcode_op_imm, 7'h24, 3'd1}: res = a & ~(32'd1 << sh);
      {opcode_op, 7'h24, 3'd5},
      {opcode_op_imm, 7'h24, 3'd5}: res = {31'd0, a[sh]};
      {opcode_op, 7'h34, 3'd1},
      {opcode_op_imm, 7'h34, 3'd1}: res = a ^ (32'd1 << sh);
      {opcode_op, 7'h14, 3'd1},
      {opcode_op_imm, 7'h14, 3'd1}: res = a | (32'd1 << sh);
      {opcode_op_imm, 7'h30, 3'd1}: begin
        case (f5)
          5'd0: begin
            for (int i = 31; i >= 0 && !a[i]; i--)
              cnt++;
            res = cnt;
          end
          5'd1: begin
            for (int i = 0; i < 32 && !a[i]; i++)
              cnt++;
            res = cnt;
          end
          5'd2: begin
            for (int i = 0; i < 32; i++)
              if (a[i]) cnt++;
            res = cnt;
          end
          5'd4: res = {{24{a[7]}}, a[7:0]};
          5'd5: res = {{16{a[15]}}, a[15:0]};
          default: ok = 1'b0;
        endcase
      end
      {opcode_op_imm, 7'h14, 3'd5}: begin
        ok = (f5 == 5'd7);
        for (int i = 0; i < 4; i++)
          res[8*i +: 8] = (a[8*i +: 8] != 8'd0) ? 8'hff : 8'h00;
      end
      {opcode_op_imm, 7'h34, 3'd5}: begin
        ok = (f5 == 5'd24);
        res = {a[7:0], a[15:8], a[23:16], a[31:24]};
      end
      default: ok = 1'b0;
    endcase
    out.res = ok ? res : 32'd0;
    out.illegal = !ok;
    return out;
  endfunction

  // One entry per supported instruction, R-type unless set otherwise.
  function automatic logic [31:0] legal_instr(input int unsigned kind, input logic [4:0] rd,
                                              input logic [4:0] rs1f, input logic [4:0] f5r);
    logic [6:0] opc;
    logic [6:0] f7;
    logic [2:0] f3;
    logic [4:0] f5;
    opc = opcode_op;
    f5 = f5r;
    case (kind)
      0: {f7, f3} = {7'h10, 3'd2};
      1: {f7, f3} = {7'h10, 3'd4};
      2: {f7, f3} = {7'h10, 3'd6};
      3: {f7, f3} = {7'h20, 3'd7};
      4: {f7, f3} = {7'h20, 3'd6};
      5: {f7, f3} = {7'h20, 3'd4};
      6: {f7, f3} = {7'h05, 3'd4};
      7: {f7, f3} = {7'h05, 3'd5};
      8: {f7, f3} = {7'h05, 3'd6};
      9: {f7, f3} = {7'h05, 3'd7};
      10: {f7, f3} = {7'h30, 3'd1};
      11: {f7, f3} = {7'h30, 3'd5};
      12: {f7, f3, f5} = {7'h04, 3'd4, 5'd0};
      13: {f7, f3} = {7'h24, 3'd1};
      14: {f7, f3} = {7'h24, 3'd5};
      15: {f7, f3} = {7'h34, 3'd1};
      16: {f7, f3} = {7'h14, 3'd1};
      17: {opc, f7, f3, f5} = {opcode_op_imm, 7'h30, 3'd1, 5'd0};
      18: {opc, f7, f3, f5} = {opcode_op_imm, 7'h30, 3'd1, 5'd1};
      19: {opc, f7, f3, f5} = {opcode_op_imm, 7'h30, 3'd1, 5'd2};
      20: {opc, f7, f3, f5} = {opcode_op_imm, 7'h30, 3'd1, 5'd4};
      21: {opc, f7, f3, f5} = {opcode_op_imm, 7'h30, 3'd1, 5'd5};
      22: {opc, f7, f3, f5} = {opcode_op_imm, 7'h14, 3'd5, 5'd7};
      23: {opc, f7, f3, f5} = {opcode_op_imm, 7'h34, 3'd5, 5'd24};
      24: {opc, f7, f3} = {opcode_op_imm, 7'h30, 3'd5};
      25: {opc, f7, f3} = {opcode_op_imm, 7'h24, 3'd1};
      26: {opc, f7, f3} = {opcode_op_imm, 7'h24, 3'd5};
      27: {opc, f7, f3} = {opcode_op_imm, 7'h34, 3'd1};
      default: {opc, f7, f3} = {opcode_op_imm, 7'h14, 3'd1};
    endcase
    return {f7, f5, rs1f, f3, rd, opc};
  endfunction

  function automatic logic [31:0] pick_operand();
    logic [31:0] v;
    case ($urandom_range(0, 7))
      0: v = 32'h0000_0000;
      1: v = 32'hffff_ffff;
      2: v = 32'h8000_0000;
      3: v = 32'h7fff_ffff;
      4: v = 32'd1 << $urandom_range(0, 31);
      default: v = $urandom;
    endcase
    return v;
  endfunction

  function automatic exec_req_type make_request();
    exec_req_type r;
    // Roughly one word in eight is random garbage.
    if ($urandom_range(0, 7) == 0) begin
      r.instr = $urandom;
    end else begin
      r.instr = legal_instr($urandom_range(0, num_legal - 1), 5'($urandom),
                            5'($urandom), 5'($urandom));
    end
    r.rs1 = pick_operand();
    r.rs2 = pick_operand();
    return r;
  endfunction

  task automatic drive_requests(input int count, input logic always_valid);
    int target;
    target = issued + count;
    while (issued < target) begin
      @(negedge clk);
      if (!req_valid || sent == issued) begin
        if (always_valid || $urandom_range(0, 3) != 0) begin
          req = make_request();
          req_valid = 1'b1;
          issued++;
        end else begin
          req_valid = 1'b0;
        end
      end
    end
    @(negedge clk);
    while (sent != issued)
      @(negedge clk);
    req_valid = 1'b0;
  endtask

  // Random stall stretches unless running at full rate.
  always @(negedge clk) begin
    if (full_rate) begin
      rsp_ready = 1'b1;
    end else if (stall_left > 0) begin
      rsp_ready = 1'b0;
      stall_left--;
    end else if ($urandom_range(0, 9) == 0) begin
      stall_left = $urandom_range(1, 10);
      rsp_ready = 1'b0;
    end else begin
      rsp_ready = 1'b1;
    end
  end

  // Samples just before each rising edge, where every signal has settled.
  always begin
    @(negedge clk);
    #sample_delay;
    cycle_cnt = cycle_cnt + 32'd1;
    if (rst_n) begin
      assert (req_ready || sb_q.size() == 2) else begin
        flow_errors++;
        $display("req_ready low at %0t with only %0d items held", $time, sb_q.size());
      end
      if (rsp_valid && rsp_ready) begin
        if (sb_q.size() == 0) begin
          flow_errors++;
          $display("Response at %0t with no request outstanding", $time);
        end else begin
          sb_entry_type e;
          e = sb_q.pop_front();
          received++;
          assert (rsp.res === e.rsp.res) else begin
            res_errors++;
            $display("ERR %0t rsp.res expected %h actual %h", $time, e.rsp.res, rsp.res);
          end
          assert (rsp.illegal === e.rsp.illegal) else begin
            illegal_errors++;
            $display("ERR %0t rsp.illegal expected %b actual %b", $time, e.rsp.illegal,
                     rsp.illegal);
          end
          assert (!e.timed || cycle_cnt - e.cycle == 32'd2) else begin
            flow_errors++;
            $display("Response at %0t took %0d cycles instead of 2", $time,
                     cycle_cnt - e.cycle);
          end
          assert (!(e.timed && last_timed) || cycle_cnt == last_rsp_cycle + 32'd1) else begin
            flow_errors++;
            $display("Gap between full-rate responses at %0t", $time);
          end
          last_rsp_cycle = cycle_cnt;
          last_timed = e.timed;
        end
      end
      if (req_valid && req_ready) begin
        sb_q.push_back('{rsp: ref_exec(req), timed: burst_mode, cycle: cycle_cnt});
        sent++;
      end
    end
  end

  initial begin
    #(watchdog_ns);
    $display("Watchdog expired with %0d of %0d responses received", received, num_txn);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    void'($urandom(77));
    rst_n = 1'b0;
    req = '0;
    req_valid = 1'b0;
    full_rate = 1'b0;
    burst_mode = 1'b0;
    stall_left = 0;
    cycle_cnt = '0;
    last_rsp_cycle = '0;
    last_timed = 1'b0;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;

    drive_requests(num_random, 1'b0);
    full_rate = 1'b1;
    while (sb_q.size() != 0)
      @(negedge clk);

    burst_mode = 1'b1;
    drive_requests(num_burst, 1'b1);
    burst_mode = 1'b0;
    for (int i = 0; i < drain_cycles && sb_q.size() != 0; i++)
      @(negedge clk);
    repeat (4) @(negedge clk);

    assert (sb_q.size() == 0) else begin
      flow_errors++;
      $display("%0d expected responses never arrived", sb_q.size());
    end
    $display("Errors: rsp.res %0d, rsp.illegal %0d, flow %0d", res_errors, illegal_errors,
             flow_errors);
    if (res_errors + illegal_errors + flow_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/bit_exec_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module bit_exec_asserts (
  input logic                       clk,
  input logic                       rst_n,
  input logic                       req_ready,
  input bitmanip_pkg::exec_rsp_type rsp,
  input logic                       rsp_valid,
  input logic                       rsp_ready
);

  // A stalled response keeps its valid and payload.
  rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
    else $error("rsp changed or rsp_valid dropped while rsp_ready was low");

  rsp_idle_after_reset: assert property (@(posedge clk) !rst_n |=> !rsp_valid)
    else $error("rsp_valid high in the cycle after reset");

  // Both stages come out of reset empty.
  req_open_after_reset: assert property (@(posedge clk) !rst_n |=> req_ready)
    else $error("req_ready low in the cycle after reset");

endmodule

bind bit_exec_unit bit_exec_asserts u_asserts (
  .clk      (clk),
  .rst_n    (rst_n),
  .req_ready(req_ready),
  .rsp      (rsp),
  .rsp_valid(rsp_valid),
  .rsp_ready(rsp_ready)
);

`default_nettype wire

// ==== hw/bit_exec_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module bit_exec_unit (
  input  logic                       clk,
  input  logic                       rst_n,
  input  bitmanip_pkg::exec_req_type req,
  input  logic                       req_valid,
  output logic                       req_ready,
  output bitmanip_pkg::exec_rsp_type rsp,
  output logic                       rsp_valid,
  input  logic                       rsp_ready
);
  import bitmanip_pkg::*;

  exec_req_type    stage_req;
  logic            stage_valid;
  logic            stage_ready;
  exec_dec_type    dec;
  bit_alu_out_type alu_out;
  exec_rsp_type    alu_rsp;

  pipe_stage #(.payload_t(exec_req_type)) u_in_stage (
    .clk      (clk),
    .rst_n    (rst_n),
    .in       (req),
    .in_valid (req_valid),
    .in_ready (req_ready),
    .out      (stage_req),
    .out_valid(stage_valid),
    .out_ready(stage_ready)
  );

  bit_decoder u_decoder (
    .req(stage_req),
    .dec(dec)
  );

  bit_alu u_alu (
    .bit_alu_in (dec.alu_in),
    .bit_alu_out(alu_out)
  );

  assign alu_rsp = '{res: alu_out.res, illegal: dec.illegal};

  pipe_stage #(.payload_t(exec_rsp_type)) u_out_stage (
    .clk      (clk),
    .rst_n    (rst_n),
    .in       (alu_rsp),
    .in_valid (stage_valid),
    .in_ready (stage_ready),
    .out      (rsp),
    .out_valid(rsp_valid),
    .out_ready(rsp_ready)
  );

endmodule

`default_nettype wire

// ==== hw/bit_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module bit_alu (
  input  bitmanip_pkg::bit_alu_in_type  bit_alu_in,
  output bitmanip_pkg::bit_alu_out_type bit_alu_out
);
  import bitmanip_pkg::*;

  logic [xlen-1:0] rs1;
  logic [xlen-1:0] rs2;
  logic [xlen-1:0] res;
  logic [1:0]      index;
  logic [1:0]      op;
  zba_op_type      zba;
  zbb_op_type      zbb;
  zbs_op_type      zbs;

  always_comb begin
    zba = bit_alu_in.bit_op.bit_zba;
    zbb = bit_alu_in.bit_op.bit_zbb;
    zbs = bit_alu_in.bit_op.bit_zbs;
    rs1 = bit_alu_in.rs1;
    rs2 = multiplexer(bit_alu_in.imm, bit_alu_in.rs2, bit_alu_in.sel);

    index = 2'd0;
    if (zba.bit_sh1add) begin
      index = 2'd1;
    end else if (zba.bit_sh2add) begin
      index = 2'd2;
    end else if (zba.bit_sh3add) begin
      index = 2'd3;
    end

    op = 2'd0;
    if (zbb.bit_maxu) begin
      op = 2'd1;
    end else if (zbb.bit_min) begin
      op = 2'd2;
    end else if (zbb.bit_minu) begin
      op = 2'd3;
    end

    // First active flag wins.
    res = '0;
    if (|zba) res = bit_shadd(rs1, rs2, index);
    else if (zbb.bit_andn) res = bit_andn(rs1, rs2);
    else if (zbb.bit_orn) res = bit_orn(rs1, rs2);
    else if (zbb.bit_xnor) res = bit_xnor(rs1, rs2);
    else if (zbb.bit_clz) res = bit_clz(rs1);
    else if (zbb.bit_cpop) res = bit_cpop(rs1);
    else if (zbb.bit_ctz) res = bit_ctz(rs1);
    else if (zbb.bit_max | zbb.bit_maxu | zbb.bit_min | zbb.bit_minu) begin
      res = bit_minmax(rs1, rs2, op);
    end
    else if (zbb.bit_orcb) res = bit_orcb(rs1);
    else if (zbb.bit_rev8) res = bit_rev8(rs1);
    else if (zbb.bit_rol) res = bit_rol(rs1, rs2);
    else if (zbb.bit_ror) res = bit_ror(rs1, rs2);
    else if (zbb.bit_sextb) res = bit_sextb(rs1);
    else if (zbb.bit_sexth) res = bit_sexth(rs1);
    else if (zbb.bit_zexth) res = bit_zexth(rs1);
    else if (zbs.bit_bclr) res = bit_bclr(rs1, rs2);
    else if (zbs.bit_bext) res = bit_bext(rs1, rs2);
    else if (zbs.bit_binv) res = bit_binv(rs1, rs2);
    else if (zbs.bit_bset) res = bit_bset(rs1, rs2);

    bit_alu_out.res = res;
  end

endmodule

`default_nettype wire

// ==== hw/bit_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module bit_decoder (
  input  bitmanip_pkg::exec_req_type req,
  output bitmanip_pkg::exec_dec_type dec
);
  import bitmanip_pkg::*;

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [4:0]      field;
  logic [xlen-1:0] imm;
  logic            sel;
  bit_op_type      op;

  always_comb begin
    opcode = req.instr[6:0];
    funct3 = req.instr[14:12];
    funct7 = req.instr[31:25];
    // rs2 for register forms, shamt or unary selector for immediates.
    field = req.instr[24:20];
    op = '0;
    sel = 1'b0;
    imm = '0;
    if (opcode == opcode_op) begin
      case ({funct7, funct3})
        {7'b0010000, 3'b010}: op.bit_zba.bit_sh1add = 1'b1;
        {7'b0010000, 3'b100}: op.bit_zba.bit_sh2add = 1'b1;
        {7'b0010000, 3'b110}: op.bit_zba.bit_sh3add = 1'b1;
        {7'b0100000, 3'b111}: op.bit_zbb.bit_andn = 1'b1;
        {7'b0100000, 3'b110}: op.bit_zbb.bit_orn = 1'b1;
        {7'b0100000, 3'b100}: op.bit_zbb.bit_xnor = 1'b1;
        {7'b0000101, 3'b110}: op.bit_zbb.bit_max = 1'b1;
        {7'b0000101, 3'b111}: op.bit_zbb.bit_maxu = 1'b1;
        {7'b0000101, 3'b100}: op.bit_zbb.bit_min = 1'b1;
        {7'b0000101, 3'b101}: op.bit_zbb.bit_minu = 1'b1;
        {7'b0110000, 3'b001}: op.bit_zbb.bit_rol = 1'b1;
        {7'b0110000, 3'b101}: op.bit_zbb.bit_ror = 1'b1;
        {7'b0000100, 3'b100}: op.bit_zbb.bit_zexth = (field == 5'b00000);
        {7'b0100100, 3'b001}: op.bit_zbs.bit_bclr = 1'b1;
        {7'b0100100, 3'b101}: op.bit_zbs.bit_bext = 1'b1;
        {7'b0110100, 3'b001}: op.bit_zbs.bit_binv = 1'b1;
        {7'b0010100, 3'b001}: op.bit_zbs.bit_bset = 1'b1;
        default: ;
      endcase
    end else if (opcode == opcode_op_imm) begin
      imm = {{(xlen-5){1'b0}}, field};
      case ({funct7, funct3})
        {7'b0110000, 3'b001}: begin
          op.bit_zbb.bit_clz = (field == 5'b00000);
          op.bit_zbb.bit_ctz = (field == 5'b00001);
          op.bit_zbb.bit_cpop = (field == 5'b00010);
          op.bit_zbb.bit_sextb = (field == 5'b00100);
          op.bit_zbb.bit_sexth = (field == 5'b00101);
        end
        {7'b0010100, 3'b101}: op.bit_zbb.bit_orcb = (field == 5'b00111);
        {7'b0110100, 3'b101}: op.bit_zbb.bit_rev8 = (field == 5'b11000);
        {7'b0110000, 3'b101}: op.bit_zbb.bit_ror = 1'b1;
        {7'b0100100, 3'b001}: op.bit_zbs.bit_bclr = 1'b1;
        {7'b0100100, 3'b101}: op.bit_zbs.bit_bext = 1'b1;
        {7'b0110100, 3'b001}: op.bit_zbs.bit_binv = 1'b1;
        {7'b0010100, 3'b001}: op.bit_zbs.bit_bset = 1'b1;
        default: ;
      endcase
      // Shift-amount forms take the immediate.
      sel = op.bit_zbb.bit_ror | (|op.bit_zbs);
    end
    dec.alu_in.rs1 = req.rs1;
    dec.alu_in.rs2 = req.rs2;
    dec.alu_in.imm = imm;
    dec.alu_in.sel = sel;
    dec.alu_in.bit_op = op;
    dec.illegal = (op == '0);
  end

endmodule

`default_nettype wire

// ==== hw/pipe_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipe_stage #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     clk,
  input  logic     rst_n,
  input  payload_t in,
  input  logic     in_valid,
  output logic     in_ready,
  output payload_t out,
  output logic     out_valid,
  input  logic     out_ready
);

  logic full;

  // Loads when empty or drained this cycle.
  assign in_ready = !full || out_ready;
  assign out_valid = full;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      full <= 1'b0;
    end else if (in_ready) begin
      full <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      out <= in;
    end
  end

endmodule

`default_nettype wire

// ==== hw/bitmanip_pkg.sv ====
`default_nettype none

package bitmanip_pkg;

  localparam int xlen = 32;

  localparam logic [6:0] opcode_op     = 7'b0110011;
  localparam logic [6:0] opcode_op_imm = 7'b0010011;

  typedef struct packed {
    logic bit_sh1add;
    logic bit_sh2add;
    logic bit_sh3add;
  } zba_op_type;

  typedef struct packed {
    logic bit_andn;
    logic bit_orn;
    logic bit_xnor;
    logic bit_clz;
    logic bit_cpop;
    logic bit_ctz;
    logic bit_max;
    logic bit_maxu;
    logic bit_min;
    logic bit_minu;
    logic bit_orcb;
    logic bit_rev8;
    logic bit_rol;
    logic bit_ror;
    logic bit_sextb;
    logic bit_sexth;
    logic bit_zexth;
  } zbb_op_type;

  typedef struct packed {
    logic bit_bclr;
    logic bit_bext;
    logic bit_binv;
    logic bit_bset;
  } zbs_op_type;

  typedef struct packed {
    zba_op_type bit_zba;
    zbb_op_type bit_zbb;
    zbs_op_type bit_zbs;
  } bit_op_type;

  // Sel high picks imm as the second operand.
  typedef struct packed {
    logic [xlen-1:0] rs1;
    logic [xlen-1:0] rs2;
    logic [xlen-1:0] imm;
    logic            sel;
    bit_op_type      bit_op;
  } bit_alu_in_type;

  typedef struct packed {
    logic [xlen-1:0] res;
  } bit_alu_out_type;

  typedef struct packed {
    logic [xlen-1:0] instr;
    logic [xlen-1:0] rs1;
    logic [xlen-1:0] rs2;
  } exec_req_type;

  typedef struct packed {
    bit_alu_in_type alu_in;
    logic           illegal;
  } exec_dec_type;

  typedef struct packed {
    logic [xlen-1:0] res;
    logic            illegal;
  } exec_rsp_type;

`include "bit_functions.svh"

endpackage

`default_nettype wire

// ==== hw/bit_functions.svh ====
`ifndef BIT_FUNCTIONS_SVH
`define BIT_FUNCTIONS_SVH

function automatic logic [xlen-1:0] multiplexer(input logic [xlen-1:0] a,
                                                input logic [xlen-1:0] b,
                                                input logic sel);
  return sel ? a : b;
endfunction

// Zba. Index is the left shift of rs1.
function automatic logic [xlen-1:0] bit_shadd(input logic [xlen-1:0] a,
                                              input logic [xlen-1:0] b,
                                              input logic [1:0] index);
  return (a << index) + b;
endfunction

function automatic logic [xlen-1:0] bit_andn(input logic [xlen-1:0] a,
                                             input logic [xlen-1:0] b);
  return a & ~b;
endfunction

function automatic logic [xlen-1:0] bit_orn(input logic [xlen-1:0] a,
                                            input logic [xlen-1:0] b);
  return a | ~b;
endfunction

function automatic logic [xlen-1:0] bit_xnor(input logic [xlen-1:0] a,
                                             input logic [xlen-1:0] b);
  return ~(a ^ b);
endfunction

function automatic logic [xlen-1:0] bit_clz(input logic [xlen-1:0] a);
  logic [xlen-1:0] cnt;
  logic            found;
  cnt = '0;
  found = 1'b0;
  for (int i = xlen - 1; i >= 0; i--) begin
    if (a[i]) begin
      found = 1'b1;
    end else if (!found) begin
      cnt = cnt + 1'b1;
    end
  end
  return cnt;
endfunction

function automatic logic [xlen-1:0] bit_ctz(input logic [xlen-1:0] a);
  logic [xlen-1:0] cnt;
  logic            found;
  cnt = '0;
  found = 1'b0;
  for (int i = 0; i < xlen; i++) begin
    if (a[i]) begin
      found = 1'b1;
    end else if (!found) begin
      cnt = cnt + 1'b1;
    end
  end
  return cnt;
endfunction

function automatic logic [xlen-1:0] bit_cpop(input logic [xlen-1:0] a);
  logic [xlen-1:0] cnt;
  cnt = '0;
  for (int i = 0; i < xlen; i++) begin
    cnt = cnt + a[i];
  end
  return cnt;
endfunction

// Op 0 max, 1 maxu, 2 min, 3 minu.
function automatic logic [xlen-1:0] bit_minmax(input logic [xlen-1:0] a,
                                               input logic [xlen-1:0] b,
                                               input logic [1:0] op);
  logic [xlen-1:0] res;
  case (op)
    2'd0: res = ($signed(a) > $signed(b)) ? a : b;
    2'd1: res = (a > b) ? a : b;
    2'd2: res = ($signed(a) < $signed(b)) ? a : b;
    default: res = (a < b) ? a : b;
  endcase
  return res;
endfunction

function automatic logic [xlen-1:0] bit_orcb(input logic [xlen-1:0] a);
  logic [xlen-1:0] res;
  for (int i = 0; i < xlen / 8; i++) begin
    res[8*i +: 8] = (|a[8*i +: 8]) ? 8'hff : 8'h00;
  end
  return res;
endfunction

function automatic logic [xlen-1:0] bit_rev8(input logic [xlen-1:0] a);
  logic [xlen-1:0] res;
  for (int i = 0; i < xlen / 8; i++) begin
    res[8*i +: 8] = a[xlen-8-8*i +: 8];
  end
  return res;
endfunction

// Rotates through a doubled word.
function automatic logic [xlen-1:0] bit_rol(input logic [xlen-1:0] a,
                                            input logic [xlen-1:0] b);
  logic [2*xlen-1:0] dbl;
  dbl = {a, a} << b[4:0];
  return dbl[2*xlen-1 -: xlen];
endfunction

function automatic logic [xlen-1:0] bit_ror(input logic [xlen-1:0] a,
                                            input logic [xlen-1:0] b);
  logic [2*xlen-1:0] dbl;
  dbl = {a, a} >> b[4:0];
  return dbl[xlen-1:0];
endfunction

function automatic logic [xlen-1:0] bit_sextb(input logic [xlen-1:0] a);
  return {{(xlen-8){a[7]}}, a[7:0]};
endfunction

function automatic logic [xlen-1:0] bit_sexth(input logic [xlen-1:0] a);
  return {{(xlen-16){a[15]}}, a[15:0]};
endfunction

function automatic logic [xlen-1:0] bit_zexth(input logic [xlen-1:0] a);
  return {{(xlen-16){1'b0}}, a[15:0]};
endfunction

// Zbs. Only b[4:0] selects the bit.
function automatic logic [xlen-1:0] bit_bclr(input logic [xlen-1:0] a,
                                             input logic [xlen-1:0] b);
  return a & ~({{(xlen-1){1'b0}}, 1'b1} << b[4:0]);
endfunction

function automatic logic [xlen-1:0] bit_bext(input logic [xlen-1:0] a,
                                             input logic [xlen-1:0] b);
  return {{(xlen-1){1'b0}}, a[b[4:0]]};
endfunction

function automatic logic [xlen-1:0] bit_binv(input logic [xlen-1:0] a,
                                             input logic [xlen-1:0] b);
  return a ^ ({{(xlen-1){1'b0}}, 1'b1} << b[4:0]);
endfunction

function automatic logic [xlen-1:0] bit_bset(input logic [xlen-1:0] a,
                                             input logic [xlen-1:0] b);
  return a | ({{(xlen-1){1'b0}}, 1'b1} << b[4:0]);
endfunction

`endif
